//--- Makefile
TOP = decodeStageTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/aluDecoder.sv
`timescale 1ns/1ns

module aluDecoder (
    input  mipsPkg::opcodeT opcode,
    input  mipsPkg::functT  funct,
    output mipsPkg::aluOpT  aluOp,
    output logic            zeroExtend
);
    import mipsPkg::*;

    // R-type operation from funct
    aluOpT functOp;

    always_comb begin
        case (funct)
            FnSll:   functOp = AluSll;
            FnSrl:   functOp = AluSrl;
            FnJr:    functOp = AluPass;
            FnAdd:   functOp = AluAdd;
            FnSub:   functOp = AluSub;
            FnAnd:   functOp = AluAnd;
            FnOr:    functOp = AluOr;
            FnXor:   functOp = AluXor;
            FnSlt:   functOp = AluSlt;
            FnMul:   functOp = AluMul;
            // addu, subu and the rest behave as add here
            default: functOp = AluAdd;
        endcase
    end

    always_comb begin
        zeroExtend = 1'b0;
        case (opcode)
            OpSpecial:  aluOp = functOp;
            OpSpecial2: aluOp = AluMul;

            OpAddi:     aluOp = AluAdd;
            OpSlti:     aluOp = AluSlt;
            // logical immediates are unsigned
            OpAndi: begin
                aluOp      = AluAnd;
                zeroExtend = 1'b1;
            end
            OpOri: begin
                aluOp      = AluOr;
                zeroExtend = 1'b1;
            end
            OpXori: begin
                aluOp      = AluXor;
                zeroExtend = 1'b1;
            end

            // address = base + offset
            OpLw, OpLh, OpLb, OpSw, OpSh, OpSb: aluOp = AluAdd;

            // compare by subtraction
            OpRegImm, OpBeq, OpBne, OpBgtz, OpBlez: aluOp = AluSub;

            OpJ, OpJal: aluOp = AluPass;
            default:    aluOp = AluPass;
        endcase
    end

endmodule

//--- design/controller.sv
`timescale 1ns/1ns

module controller (
    input  mipsPkg::opcodeT      opcode,
    input  mipsPkg::functT       funct,
    output logic                 regSrc0,
    output logic                 regSrc1,
    output logic                 regDst,
    output logic                 aluSrc0,
    output mipsPkg::aluSrc1T     aluSrc1,
    output logic                 readEnable,
    output logic                 writeEnable,
    output logic                 memToReg,
    output logic                 regWrite,
    output mipsPkg::accessWidthT readWidth,
    output mipsPkg::accessWidthT writeWidth
);
    import mipsPkg::*;

    always_comb begin
        // unknown opcodes fall through with everything cleared
        regSrc0     = 1'b0;
        regSrc1     = 1'b0;
        regDst      = 1'b0;
        aluSrc0     = 1'b0;
        aluSrc1     = Src1Reg;
        readEnable  = 1'b0;
        writeEnable = 1'b0;
        memToReg    = 1'b0;
        regWrite    = 1'b0;
        readWidth   = WidthWord;
        writeWidth  = WidthWord;

        case (opcode)
            ////////////////////////////////////////////////////////////////////////////
            // register-register
            ////////////////////////////////////////////////////////////////////////////
            OpSpecial: begin
                regSrc1 = 1'b1;
                regDst  = 1'b1;
                case (funct)
                    FnJr: begin
                        regSrc0 = 1'b1;
                    end
                    // shifts take shamt on the first operand
                    FnSll: begin
                        aluSrc0  = 1'b1;
                        regWrite = 1'b1;
                    end
                    FnSrl: begin
                        aluSrc0  = 1'b1;
                        memToReg = 1'b1;
                        regWrite = 1'b1;
                    end
                    default: begin
                        memToReg = 1'b1;
                        regWrite = 1'b1;
                    end
                endcase
            end

            // mul, same pattern as generic R-type
            OpSpecial2: begin
                regSrc1  = 1'b1;
                regDst   = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end

            ////////////////////////////////////////////////////////////////////////////
            // loads and stores
            ////////////////////////////////////////////////////////////////////////////
            OpLw, OpLh, OpLb: begin
                regSrc1    = 1'b1;
                aluSrc1    = Src1Imm;
                readEnable = 1'b1;
                regWrite   = 1'b1;
                readWidth  = (opcode == OpLw) ? WidthWord :
                             (opcode == OpLh) ? WidthHalf : WidthByte;
            end

            OpSw, OpSh, OpSb: begin
                regSrc1     = 1'b1;
                aluSrc1     = Src1Imm;
                writeEnable = 1'b1;
                writeWidth  = (opcode == OpSw) ? WidthWord :
                              (opcode == OpSh) ? WidthHalf : WidthByte;
            end

            ////////////////////////////////////////////////////////////////////////////
            // branches and jumps
            ////////////////////////////////////////////////////////////////////////////
            // bgez/bltz and blez compare rs against zero only
            OpRegImm, OpBlez: begin
                regSrc1 = 1'b0;
            end

            OpBeq, OpBne, OpBgtz, OpJ: begin
                regSrc1 = 1'b1;
            end

            OpJal: begin
                regSrc1  = 1'b1;
                aluSrc1  = Src1Link;
                regWrite = 1'b1;
            end

            // immediate arithmetic and logic
            OpAddi, OpAndi, OpOri, OpXori, OpSlti: begin
                regSrc1  = 1'b1;
                aluSrc1  = Src1Imm;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end

            default: begin
                regSrc1 = 1'b0;
            end
        endcase
    end

endmodule

//--- design/decodeRegister.sv
`timescale 1ns/1ns

module decodeRegister #(
    parameter int DataWidth = 32
) (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  instrValid,
    input  logic                  regSrc0,
    input  logic                  regSrc1,
    input  logic                  regDst,
    input  logic                  aluSrc0,
    input  mipsPkg::aluSrc1T      aluSrc1,
    input  logic                  readEnable,
    input  logic                  writeEnable,
    input  logic                  memToReg,
    input  logic                  regWrite,
    input  mipsPkg::accessWidthT  readWidth,
    input  mipsPkg::accessWidthT  writeWidth,
    input  mipsPkg::aluOpT        aluOp,
    input  logic                  zeroExtend,
    input  logic [4:0]            rs,
    input  logic [4:0]            rt,
    input  logic [4:0]            rd,
    input  logic [4:0]            shamt,
    input  logic [15:0]           imm,
    output logic                  regSrc0Out,
    output logic                  regSrc1Out,
    output logic                  regDstOut,
    output logic                  aluSrc0Out,
    output mipsPkg::aluSrc1T      aluSrc1Out,
    output logic                  readEnableOut,
    output logic                  writeEnableOut,
    output logic                  memToRegOut,
    output logic                  regWriteOut,
    output mipsPkg::accessWidthT  readWidthOut,
    output mipsPkg::accessWidthT  writeWidthOut,
    output mipsPkg::aluOpT        aluOpOut,
    output logic [4:0]            rsOut,
    output logic [4:0]            rtOut,
    output logic [4:0]            writeReg,
    output logic [4:0]            shamtOut,
    output logic [DataWidth-1:0]  immExt,
    output logic                  outValid
);
    import mipsPkg::*;

    logic                 load;
    logic [4:0]           writeRegNext;
    logic [DataWidth-1:0] immExtNext;

    assign load = instrValid && !flush;

    // jal links to $ra, R-type writes rd, the rest write rt
    assign writeRegNext = (aluSrc1 == Src1Link) ? LinkReg :
                          regDst                ? rd      : rt;

    assign immExtNext = zeroExtend ? {{(DataWidth-16){1'b0}}, imm}
                                   : {{(DataWidth-16){imm[15]}}, imm};

    // state that must read low on a bubble
    always_ff @(posedge Clk) begin
        if (rst) begin
            outValid       <= 1'b0;
            regWriteOut    <= 1'b0;
            readEnableOut  <= 1'b0;
            writeEnableOut <= 1'b0;
        end else begin
            outValid       <= load;
            regWriteOut    <= regWrite && load;
            readEnableOut  <= readEnable && load;
            writeEnableOut <= writeEnable && load;
        end
    end

    // payload, only meaningful while outValid is high
    always_ff @(posedge Clk) begin
        regSrc0Out    <= regSrc0;
        regSrc1Out    <= regSrc1;
        regDstOut     <= regDst;
        aluSrc0Out    <= aluSrc0;
        aluSrc1Out    <= aluSrc1;
        memToRegOut   <= memToReg;
        readWidthOut  <= readWidth;
        writeWidthOut <= writeWidth;
        aluOpOut      <= aluOp;
        rsOut         <= rs;
        rtOut         <= rt;
        writeReg      <= writeRegNext;
        shamtOut      <= shamt;
        immExt        <= immExtNext;
    end

endmodule

//--- design/decodeStage.sv
`timescale 1ns/1ns

module decodeStage #(
    parameter int DataWidth = 32
) (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic [31:0]           instr,
    input  logic                  instrValid,
    input  logic                  flush,
    output logic                  regSrc0Out,
    output logic                  regSrc1Out,
    output logic                  regDstOut,
    output logic                  aluSrc0Out,
    output mipsPkg::aluSrc1T      aluSrc1Out,
    output logic                  readEnableOut,
    output logic                  writeEnableOut,
    output logic                  memToRegOut,
    output logic                  regWriteOut,
    output mipsPkg::accessWidthT  readWidthOut,
    output mipsPkg::accessWidthT  writeWidthOut,
    output mipsPkg::aluOpT        aluOpOut,
    output logic [4:0]            rsOut,
    output logic [4:0]            rtOut,
    output logic [4:0]            writeReg,
    output logic [4:0]            shamtOut,
    output logic [DataWidth-1:0]  immExt,
    output logic                  outValid
);
    import mipsPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // field split
    ////////////////////////////////////////////////////////////////////////////
    opcodeT      opcode;
    functT       funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] imm;

    assign opcode = opcodeT'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = functT'(instr[5:0]);
    assign imm    = instr[15:0];

    // decoder outputs
    logic        regSrc0;
    logic        regSrc1;
    logic        regDst;
    logic        aluSrc0;
    aluSrc1T     aluSrc1;
    logic        readEnable;
    logic        writeEnable;
    logic        memToReg;
    logic        regWrite;
    accessWidthT readWidth;
    accessWidthT writeWidth;
    aluOpT       aluOp;
    logic        zeroExtend;

    ////////////////////////////////////////////////////////////////////////////
    // decoders and ID/EX register
    ////////////////////////////////////////////////////////////////////////////
    controller ctrl (
        .opcode      (opcode),
        .funct       (funct),
        .regSrc0     (regSrc0),
        .regSrc1     (regSrc1),
        .regDst      (regDst),
        .aluSrc0     (aluSrc0),
        .aluSrc1     (aluSrc1),
        .readEnable  (readEnable),
        .writeEnable (writeEnable),
        .memToReg    (memToReg),
        .regWrite    (regWrite),
        .readWidth   (readWidth),
        .writeWidth  (writeWidth)
    );

    aluDecoder aluDec (
        .opcode     (opcode),
        .funct      (funct),
        .aluOp      (aluOp),
        .zeroExtend (zeroExtend)
    );

    decodeRegister #(
        .DataWidth (DataWidth)
    ) idEx (
        .Clk            (Clk),
        .rst            (rst),
        .flush          (flush),
        .instrValid     (instrValid),
        .regSrc0        (regSrc0),
        .regSrc1        (regSrc1),
        .regDst         (regDst),
        .aluSrc0        (aluSrc0),
        .aluSrc1        (aluSrc1),
        .readEnable     (readEnable),
        .writeEnable    (writeEnable),
        .memToReg       (memToReg),
        .regWrite       (regWrite),
        .readWidth      (readWidth),
        .writeWidth     (writeWidth),
        .aluOp          (aluOp),
        .zeroExtend     (zeroExtend),
        .rs             (rs),
        .rt             (rt),
        .rd             (rd),
        .shamt          (shamt),
        .imm            (imm),
        .regSrc0Out     (regSrc0Out),
        .regSrc1Out     (regSrc1Out),
        .regDstOut      (regDstOut),
        .aluSrc0Out     (aluSrc0Out),
        .aluSrc1Out     (aluSrc1Out),
        .readEnableOut  (readEnableOut),
        .writeEnableOut (writeEnableOut),
        .memToRegOut    (memToRegOut),
        .regWriteOut    (regWriteOut),
        .readWidthOut   (readWidthOut),
        .writeWidthOut  (writeWidthOut),
        .aluOpOut       (aluOpOut),
        .rsOut          (rsOut),
        .rtOut          (rtOut),
        .writeReg       (writeReg),
        .shamtOut       (shamtOut),
        .immExt         (immExt),
        .outValid       (outValid)
    );

endmodule

//--- design/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////////

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OpSpecial  = 6'b000000,
        OpRegImm   = 6'b000001,  // bgez and bltz, told apart by rt
        OpJ        = 6'b000010,
        OpJal      = 6'b000011,
        OpBeq      = 6'b000100,
        OpBne      = 6'b000101,
        OpBlez     = 6'b000110,
        OpBgtz     = 6'b000111,
        OpAddi     = 6'b001000,
        OpSlti     = 6'b001010,
        OpAndi     = 6'b001100,
        OpOri      = 6'b001101,
        OpXori     = 6'b001110,
        OpSpecial2 = 6'b011100,  // mul only
        OpLb       = 6'b100000,
        OpLh       = 6'b100001,
        OpLw       = 6'b100011,
        OpSb       = 6'b101000,
        OpSh       = 6'b101001,
        OpSw       = 6'b101011
    } opcodeT;

    // funct field, instr[5:0]; other values decode as generic R-type
    typedef enum logic [5:0] {
        FnSll = 6'b000000,
        FnSrl = 6'b000010,
        FnJr  = 6'b001000,
        // mult under SPECIAL; SPECIAL2 mul shares funct 000010 with srl
        FnMul = 6'b011000,
        FnAdd = 6'b100000,
        FnSub = 6'b100010,
        FnAnd = 6'b100100,
        FnOr  = 6'b100101,
        FnXor = 6'b100110,
        FnSlt = 6'b101010
    } functT;

    ////////////////////////////////////////////////////////////////////////////
    // datapath controls
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluAnd  = 4'd2,
        AluOr   = 4'd3,
        AluXor  = 4'd4,
        AluSlt  = 4'd5,
        AluSll  = 4'd6,
        AluSrl  = 4'd7,
        AluMul  = 4'd8,
        AluPass = 4'd9
    } aluOpT;

    // second ALU operand
    typedef enum logic [1:0] {
        Src1Reg  = 2'd0,
        Src1Imm  = 2'd1,
        Src1Link = 2'd2   // return address for jal
    } aluSrc1T;

    // memory access size
    typedef enum logic [1:0] {
        WidthWord = 2'd0,
        WidthHalf = 2'd1,
        WidthByte = 2'd2
    } accessWidthT;

    // $ra
    localparam logic [4:0] LinkReg = 5'd31;

endpackage

//--- files.f
+incdir+tb
design/mipsPkg.sv
design/controller.sv
design/aluDecoder.sv
design/decodeRegister.sv
design/decodeStage.sv
tb/decodeStageTb.sv

//--- tb/decodeModel.svh
// expected decode, written as tables from the instruction set
// control bits, MSB first:
// regSrc0 regSrc1 regDst aluSrc0 aluSrc1[1:0] readEnable writeEnable
// memToReg regWrite readWidth[1:0] writeWidth[1:0]

function automatic logic [13:0] expCtrl(input logic [5:0] op, input logic [5:0] fn);
    case (op)
        OpSpecial: begin
            case (fn)
                FnJr:    return 14'b1_1_1_0_00_0_0_0_0_00_00;
                FnSll:   return 14'b0_1_1_1_00_0_0_0_1_00_00;
                FnSrl:   return 14'b0_1_1_1_00_0_0_1_1_00_00;
                default: return 14'b0_1_1_0_00_0_0_1_1_00_00;
            endcase
        end
        OpSpecial2: return 14'b0_1_1_0_00_0_0_1_1_00_00;
        // loads, width in readWidth
        OpLw:       return 14'b0_1_0_0_01_1_0_0_1_00_00;
        OpLh:       return 14'b0_1_0_0_01_1_0_0_1_01_00;
        OpLb:       return 14'b0_1_0_0_01_1_0_0_1_10_00;
        // stores, width in writeWidth
        OpSw:       return 14'b0_1_0_0_01_0_1_0_0_00_00;
        OpSh:       return 14'b0_1_0_0_01_0_1_0_0_00_01;
        OpSb:       return 14'b0_1_0_0_01_0_1_0_0_00_10;
        OpRegImm:   return 14'b0_0_0_0_00_0_0_0_0_00_00;
        OpBlez:     return 14'b0_0_0_0_00_0_0_0_0_00_00;
        OpBeq:      return 14'b0_1_0_0_00_0_0_0_0_00_00;
        OpBne:      return 14'b0_1_0_0_00_0_0_0_0_00_00;
        OpBgtz:     return 14'b0_1_0_0_00_0_0_0_0_00_00;
        OpJ:        return 14'b0_1_0_0_00_0_0_0_0_00_00;
        OpJal:      return 14'b0_1_0_0_10_0_0_0_1_00_00;
        OpAddi:     return 14'b0_1_0_0_01_0_0_1_1_00_00;
        OpAndi:     return 14'b0_1_0_0_01_0_0_1_1_00_00;
        OpOri:      return 14'b0_1_0_0_01_0_0_1_1_00_00;
        OpXori:     return 14'b0_1_0_0_01_0_0_1_1_00_00;
        OpSlti:     return 14'b0_1_0_0_01_0_0_1_1_00_00;
        default:    return 14'b0;
    endcase
endfunction

function automatic aluOpT expAluOp(input logic [5:0] op, input logic [5:0] fn);
    if (op == OpSpecial) begin
        if (fn == FnSll) return AluSll;
        if (fn == FnSrl) return AluSrl;
        if (fn == FnJr) return AluPass;
        if (fn == FnSub) return AluSub;
        if (fn == FnAnd) return AluAnd;
        if (fn == FnOr) return AluOr;
        if (fn == FnXor) return AluXor;
        if (fn == FnSlt) return AluSlt;
        if (fn == FnMul) return AluMul;
        return AluAdd;
    end
    if (op == OpSpecial2) return AluMul;
    if (op == OpAndi) return AluAnd;
    if (op == OpOri) return AluOr;
    if (op == OpXori) return AluXor;
    if (op == OpSlti) return AluSlt;
    if (op == OpAddi || op == OpLw || op == OpLh || op == OpLb) return AluAdd;
    if (op == OpSw || op == OpSh || op == OpSb) return AluAdd;
    if (op == OpRegImm || op == OpBeq || op == OpBne) return AluSub;
    if (op == OpBgtz || op == OpBlez) return AluSub;
    return AluPass;
endfunction

// only the logical immediates are unsigned
function automatic logic [31:0] expImm(input logic [5:0] op, input logic [15:0] imm);
    if (op == OpAndi || op == OpOri || op == OpXori)
        return {16'h0000, imm};
    return {{16{imm[15]}}, imm};
endfunction

function automatic logic [4:0] expWriteReg(input logic [13:0] ctrl, input logic [4:0] rt,
                                           input logic [4:0] rd);
    if (ctrl[9:8] == 2'd2) return 5'd31;
    if (ctrl[11]) return rd;
    return rt;
endfunction

//--- tb/decodeStageTb.sv
`timescale 1ns/1ns

module decodeStageTb;
    import mipsPkg::*;

    localparam int DataWidth     = 32;
    localparam int DriveDelay    = 2;
    localparam int ResetCycles   = 16;
    // reset 20, table 62, memory 12, immediates 14, pipeline 10
    localparam int TestCycles    = 118;
    localparam int TimeoutCycles = 2 * TestCycles;

    logic                 Clk;
    logic                 rst;
    logic [31:0]          instr;
    logic                 instrValid;
    logic                 flush;
    logic                 regSrc0Out;
    logic                 regSrc1Out;
    logic                 regDstOut;
    logic                 aluSrc0Out;
    aluSrc1T              aluSrc1Out;
    logic                 readEnableOut;
    logic                 writeEnableOut;
    logic                 memToRegOut;
    logic                 regWriteOut;
    accessWidthT          readWidthOut;
    accessWidthT          writeWidthOut;
    aluOpT                aluOpOut;
    logic [4:0]           rsOut;
    logic [4:0]           rtOut;
    logic [4:0]           writeReg;
    logic [4:0]           shamtOut;
    logic [DataWidth-1:0] immExt;
    logic                 outValid;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          cycles;

    `include "decodeModel.svh"

    decodeStage #(
        .DataWidth (DataWidth)
    ) dut (
        .Clk            (Clk),
        .rst            (rst),
        .instr          (instr),
        .instrValid     (instrValid),
        .flush          (flush),
        .regSrc0Out     (regSrc0Out),
        .regSrc1Out     (regSrc1Out),
        .regDstOut      (regDstOut),
        .aluSrc0Out     (aluSrc0Out),
        .aluSrc1Out     (aluSrc1Out),
        .readEnableOut  (readEnableOut),
        .writeEnableOut (writeEnableOut),
        .memToRegOut    (memToRegOut),
        .regWriteOut    (regWriteOut),
        .readWidthOut   (readWidthOut),
        .writeWidthOut  (writeWidthOut),
        .aluOpOut       (aluOpOut),
        .rsOut          (rsOut),
        .rtOut          (rtOut),
        .writeReg       (writeReg),
        .shamtOut       (shamtOut),
        .immExt         (immExt),
        .outValid       (outValid)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // watchdog
    always @(posedge Clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // random fields and compares
    ////////////////////////////////////////////////////////////////////////////

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic logic [31:0] makeInstr(input logic [5:0] op, input logic [5:0] fn);
        logic [31:0] word;
        word = randBits(26);
        word[31:26] = op;
        if (op == OpSpecial || op == OpSpecial2)
            word[5:0] = fn;
        return word;
    endfunction

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkReg(input string name, input logic [4:0] expected,
                            input logic [4:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkAluOp(input string name, input aluOpT expected, input aluOpT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkWidth(input string name, input accessWidthT expected,
                              input accessWidthT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkSrc1(input string name, input aluSrc1T expected,
                             input aluSrc1T actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkData(input string name, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // whole registered result against the model
    task automatic checkResult(input logic [31:0] word);
        logic [13:0] ctrl;
        ctrl = expCtrl(word[31:26], word[5:0]);
        checkBit("outValid", 1'b1, outValid);
        checkBit("regSrc0", ctrl[13], regSrc0Out);
        checkBit("regSrc1", ctrl[12], regSrc1Out);
        checkBit("regDst", ctrl[11], regDstOut);
        checkBit("aluSrc0", ctrl[10], aluSrc0Out);
        checkSrc1("aluSrc1", aluSrc1T'(ctrl[9:8]), aluSrc1Out);
        checkBit("readEnable", ctrl[7], readEnableOut);
        checkBit("writeEnable", ctrl[6], writeEnableOut);
        checkBit("memToReg", ctrl[5], memToRegOut);
        checkBit("regWrite", ctrl[4], regWriteOut);
        checkWidth("readWidth", accessWidthT'(ctrl[3:2]), readWidthOut);
        checkWidth("writeWidth", accessWidthT'(ctrl[1:0]), writeWidthOut);
        checkAluOp("aluOp", expAluOp(word[31:26], word[5:0]), aluOpOut);
        checkReg("rsOut", word[25:21], rsOut);
        checkReg("rtOut", word[20:16], rtOut);
        checkReg("writeReg", expWriteReg(ctrl, word[20:16], word[15:11]), writeReg);
        checkReg("shamtOut", word[10:6], shamtOut);
        checkData("immExt", expImm(word[31:26], word[15:0]), immExt);
    endtask

    task automatic checkBubble();
        checkBit("outValid", 1'b0, outValid);
        checkBit("regWrite", 1'b0, regWriteOut);
        checkBit("readEnable", 1'b0, readEnableOut);
        checkBit("writeEnable", 1'b0, writeEnableOut);
    endtask

    // one strobe with its result checked a cycle later
    task automatic runOne(input logic [5:0] op, input logic [5:0] fn, input logic immMsb);
        logic [31:0] word;
        word = makeInstr(op, fn);
        if (immMsb)
            word[15] = 1'b1;
        @(posedge Clk);
        #DriveDelay;
        instr      = word;
        instrValid = 1'b1;
        @(posedge Clk);
        #DriveDelay;
        instrValid = 1'b0;
        checkResult(word);
    endtask

    task automatic checkMemory(input logic readEn, input logic writeEn, input accessWidthT width);
        checkBit("readEnable", readEn, readEnableOut);
        checkBit("writeEnable", writeEn, writeEnableOut);
        if (readEn)
            checkWidth("readWidth", width, readWidthOut);
        else
            checkWidth("writeWidth", width, writeWidthOut);
    endtask

    // imm MSB is forced high so sign extension fills with ones
    task automatic checkExtension(input logic zero);
        checkData("immExt", zero ? {16'h0000, instr[15:0]} : {16'hffff, instr[15:0]}, immExt);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testResetIdle();
        rst = 1'b1;
        repeat (ResetCycles) begin
            @(posedge Clk);
            #DriveDelay;
            checkBubble();
        end
        rst = 1'b0;
        repeat (4) begin
            @(posedge Clk);
            #DriveDelay;
            checkBubble();
        end
    endtask

    task automatic testOpcodeTable();
        logic [5:0] functs [11] = '{FnSll, FnSrl, FnJr, FnAdd, FnSub, FnAnd, FnOr,
                                    FnXor, FnSlt, FnMul, 6'b100001};
        logic [5:0] opcodes [20] = '{OpSpecial2, OpLw, OpLh, OpLb, OpSw, OpSh, OpSb,
                                     OpRegImm, OpBeq, OpBne, OpBgtz, OpBlez, OpJ, OpJal,
                                     OpAddi, OpAndi, OpOri, OpXori, OpSlti, 6'b111111};
        foreach (functs[i])
            runOne(OpSpecial, functs[i], 1'b0);
        // funct 000010 is mul under SPECIAL2
        foreach (opcodes[i])
            runOne(opcodes[i], 6'b000010, 1'b0);
    endtask

    task automatic testMemoryWidths();
        runOne(OpLw, 6'd0, 1'b0);
        checkMemory(1'b1, 1'b0, WidthWord);
        runOne(OpLh, 6'd0, 1'b0);
        checkMemory(1'b1, 1'b0, WidthHalf);
        runOne(OpLb, 6'd0, 1'b0);
        checkMemory(1'b1, 1'b0, WidthByte);
        runOne(OpSw, 6'd0, 1'b0);
        checkMemory(1'b0, 1'b1, WidthWord);
        runOne(OpSh, 6'd0, 1'b0);
        checkMemory(1'b0, 1'b1, WidthHalf);
        runOne(OpSb, 6'd0, 1'b0);
        checkMemory(1'b0, 1'b1, WidthByte);
    endtask

    task automatic testImmediates();
        runOne(OpAndi, 6'd0, 1'b1);
        checkExtension(1'b1);
        runOne(OpOri, 6'd0, 1'b1);
        checkExtension(1'b1);
        runOne(OpXori, 6'd0, 1'b1);
        checkExtension(1'b1);
        runOne(OpAddi, 6'd0, 1'b1);
        checkExtension(1'b0);
        runOne(OpSlti, 6'd0, 1'b1);
        checkExtension(1'b0);
        runOne(OpLw, 6'd0, 1'b1);
        checkExtension(1'b0);
        runOne(OpBeq, 6'd0, 1'b1);
        checkExtension(1'b0);
    endtask

    task automatic testPipeline();
        logic [31:0] words [4];
        logic [31:0] gapWord;
        words[0] = makeInstr(OpLw, 6'd0);
        words[1] = makeInstr(OpSpecial, FnAdd);
        words[2] = makeInstr(OpSw, 6'd0);
        words[3] = makeInstr(OpJal, 6'd0);
        // each result shows up while the next one is strobed
        for (int i = 0; i < 4; i++) begin
            @(posedge Clk);
            #DriveDelay;
            if (i > 0)
                checkResult(words[i-1]);
            instr      = words[i];
            instrValid = 1'b1;
        end
        @(posedge Clk);
        #DriveDelay;
        checkResult(words[3]);
        // flushed load
        instr = makeInstr(OpLw, 6'd0);
        flush = 1'b1;
        @(posedge Clk);
        #DriveDelay;
        instrValid = 1'b0;
        flush      = 1'b0;
        checkBubble();
        // strobe, gap, strobe
        gapWord    = makeInstr(OpAddi, 6'd0);
        instr      = gapWord;
        instrValid = 1'b1;
        @(posedge Clk);
        #DriveDelay;
        instrValid = 1'b0;
        checkResult(gapWord);
        @(posedge Clk);
        #DriveDelay;
        checkBubble();
        runOne(OpSpecial, FnSub, 1'b0);
    endtask

    initial begin
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        flush      = 1'b0;
        lfsr       = 32'hd522b49b;
        checks     = 0;
        errors     = 0;
        cycles     = 0;

        testResetIdle();
        testOpcodeTable();
        testMemoryWidths();
        testImmediates();
        testPipeline();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
